// ==== rtl/axi_pkg.sv ====
package axi_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    localparam int AXI_ADDR_W = 16;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ID_W   = 5;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    ////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////

    // AW and AR carry the same fields
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        axi_burst_e            burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

endpackage

// ==== rtl/loader_pkg.sv ====
package loader_pkg;

    // One queued burst request
    typedef struct packed {
        logic                          write;
        logic [7:0]                    len;
        logic [axi_pkg::AXI_ID_W-1:0]  id;
    } loader_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        AX_HANDSHAKE,
        RESP_WAIT
    } loader_state_e;

    // Data is the final read beat, zero for writes
    typedef struct packed {
        logic                           write;
        logic [axi_pkg::AXI_ID_W-1:0]   id;
        logic [axi_pkg::AXI_DATA_W-1:0] data;
    } loader_cpl_t;

endpackage

// ==== rtl/cmd_fifo.sv ====
`timescale 1ns/100ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk_i,
    input  logic                    arstn_i,

    input  loader_pkg::loader_cmd_t data_i,
    input  logic                    valid_i,
    output logic                    ready_o,

    output loader_pkg::loader_cmd_t data_o,
    output logic                    valid_o,
    input  logic                    ready_i
);

    import loader_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    loader_cmd_t      mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push, pop;

    assign ready_o = (count_q != CNT_W'(FIFO_DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// ==== rtl/axi_burst_loader.sv ====
`timescale 1ns/100ps

module axi_burst_loader #(
    parameter int LOADER_ID = 3
) (
    input  logic                    clk_i,
    input  logic                    arstn_i,

    input  logic                    start_i,
    input  logic [7:0]              req_depth_i,
    output logic                    idle_o,

    input  loader_pkg::loader_cmd_t cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,

    output axi_pkg::axi_aw_t        aw_o,
    output logic                    aw_valid_o,
    input  logic                    aw_ready_i,
    output axi_pkg::axi_w_t         w_o,
    output logic                    w_valid_o,
    input  logic                    w_ready_i,
    output axi_pkg::axi_ar_t        ar_o,
    output logic                    ar_valid_o,
    input  logic                    ar_ready_i,
    input  axi_pkg::axi_b_t         b_i,
    input  logic                    b_valid_i,
    output logic                    b_ready_o,
    input  axi_pkg::axi_r_t         r_i,
    input  logic                    r_valid_i,
    output logic                    r_ready_o
);

    import axi_pkg::*;
    import loader_pkg::*;

    localparam logic [AXI_ADDR_W-1:0] LOADER_ADDR = AXI_ADDR_W'(LOADER_ID * 4);
    localparam logic [AXI_DATA_W-1:0] WR_DATA     = AXI_DATA_W'(32'h30 + LOADER_ID);
    localparam logic [2:0]            BEAT_SIZE   = 3'($clog2(AXI_STRB_W));

    loader_state_e state_q, state_d;
    logic [7:0]    req_q, req_d;
    logic [7:0]    beat_q, beat_d;
    logic [7:0]    b_cnt_q, b_cnt_d;
    logic [7:0]    r_cnt_q, r_cnt_d;
    logic          aw_done_q, aw_done_d;
    logic          w_done_q, w_done_d;
    logic          w_last;
    logic          b_hs, r_last_hs;

    ////////////////////////////////////////
    // Fixed AXI fields
    ////////////////////////////////////////

    assign w_last = (beat_q == cmd_i.len);

    assign aw_o = '{id: cmd_i.id, addr: LOADER_ADDR, len: cmd_i.len,
                    size: BEAT_SIZE, burst: INCR};
    assign ar_o = '{id: cmd_i.id, addr: LOADER_ADDR, len: cmd_i.len,
                    size: BEAT_SIZE, burst: INCR};
    assign w_o  = '{data: WR_DATA, strb: {AXI_STRB_W{1'b1}}, last: w_last};

    // Responses are never stalled
    assign b_ready_o = 1'b1;
    assign r_ready_o = 1'b1;

    assign b_hs      = b_valid_i & b_ready_o & (b_i.resp == AXI_RESP_OKAY);
    assign r_last_hs = r_valid_i & r_ready_o & r_i.last;

    assign idle_o = (state_q == IDLE);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q   <= IDLE;
            req_q     <= '0;
            beat_q    <= '0;
            b_cnt_q   <= '0;
            r_cnt_q   <= '0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            req_q     <= req_d;
            beat_q    <= beat_d;
            b_cnt_q   <= b_cnt_d;
            r_cnt_q   <= r_cnt_d;
            aw_done_q <= aw_done_d;
            w_done_q  <= w_done_d;
        end
    end

    ////////////////////////////////////////
    // Burst issue
    ////////////////////////////////////////

    // A write is popped only once both AW and the last W beat are through
    always_comb begin
        aw_valid_o  = 1'b0;
        w_valid_o   = 1'b0;
        ar_valid_o  = 1'b0;
        cmd_ready_o = 1'b0;
        aw_done_d   = aw_done_q;
        w_done_d    = w_done_q;
        beat_d      = beat_q;

        if (state_q == AX_HANDSHAKE && cmd_valid_i) begin
            if (cmd_i.write) begin
                aw_valid_o  = !aw_done_q;
                w_valid_o   = !w_done_q;
                aw_done_d   = aw_done_q | (aw_valid_o & aw_ready_i);
                w_done_d    = w_done_q | (w_valid_o & w_ready_i & w_last);
                beat_d      = beat_q + 8'(w_valid_o & w_ready_i);
                cmd_ready_o = aw_done_d & w_done_d;
            end else begin
                ar_valid_o  = 1'b1;
                cmd_ready_o = ar_ready_i;
            end
        end

        if (cmd_ready_o) begin
            aw_done_d = 1'b0;
            w_done_d  = 1'b0;
            beat_d    = '0;
        end
    end

    ////////////////////////////////////////
    // Batch control
    ////////////////////////////////////////

    always_comb begin
        b_cnt_d = b_cnt_q + 8'(cmd_ready_o & cmd_i.write) - 8'(b_hs);
        r_cnt_d = r_cnt_q + 8'(cmd_ready_o & !cmd_i.write) - 8'(r_last_hs);
        state_d = state_q;
        req_d   = req_depth_i;

        case (state_q)
            IDLE: begin
                if (start_i && cmd_valid_i) begin
                    state_d = AX_HANDSHAKE;
                end
            end
            AX_HANDSHAKE: begin
                req_d = req_q - 8'(cmd_ready_o);
                if (cmd_ready_o && req_q == 8'd1) begin
                    state_d = RESP_WAIT;
                end else if (!cmd_valid_i && b_cnt_q == '0 && r_cnt_q == '0) begin
                    // Queue ran dry with nothing in flight
                    state_d = RESP_WAIT;
                end
            end
            RESP_WAIT: begin
                if (b_cnt_q == '0 && r_cnt_q == '0) begin
                    state_d = cmd_valid_i ? AX_HANDSHAKE : IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

// ==== rtl/axi_mem_target.sv ====
`timescale 1ns/100ps

module axi_mem_target #(
    parameter int MEM_WORDS = 16
) (
    input  logic             clk_i,
    input  logic             arstn_i,

    input  axi_pkg::axi_aw_t aw_i,
    input  logic             aw_valid_i,
    output logic             aw_ready_o,
    input  axi_pkg::axi_w_t  w_i,
    input  logic             w_valid_i,
    output logic             w_ready_o,
    input  axi_pkg::axi_ar_t ar_i,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    output axi_pkg::axi_b_t  b_o,
    output logic             b_valid_o,
    input  logic             b_ready_i,
    output axi_pkg::axi_r_t  r_o,
    output logic             r_valid_o,
    input  logic             r_ready_i
);

    import axi_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [AXI_DATA_W-1:0] mem_q [MEM_WORDS];

    logic                  w_data_q, b_valid_q;
    logic [IDX_W-1:0]      w_idx_q;
    logic [AXI_ID_W-1:0]   w_id_q;

    logic                  r_active_q;
    logic [IDX_W-1:0]      r_idx_q;
    logic [AXI_ID_W-1:0]   r_id_q;
    logic [7:0]            r_left_q;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (idx == IDX_W'(MEM_WORDS - 1)) ? '0 : idx + 1'b1;
    endfunction

    function automatic logic [IDX_W-1:0] start_idx(input logic [AXI_ADDR_W-1:0] addr);
        return IDX_W'((addr >> 2) % MEM_WORDS);
    endfunction

    ////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////

    assign aw_ready_o = !w_data_q && !b_valid_q;
    assign w_ready_o  = w_data_q;
    assign b_valid_o  = b_valid_q;
    assign b_o        = '{id: w_id_q, resp: AXI_RESP_OKAY};

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            w_data_q  <= 1'b0;
            b_valid_q <= 1'b0;
            w_idx_q   <= '0;
            w_id_q    <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (aw_valid_i && aw_ready_o) begin
                w_data_q <= 1'b1;
                w_idx_q  <= start_idx(aw_i.addr);
                w_id_q   <= aw_i.id;
            end
            if (w_valid_i && w_ready_o) begin
                for (int i = 0; i < AXI_STRB_W; i++) begin
                    if (w_i.strb[i]) begin
                        mem_q[w_idx_q][8*i +: 8] <= w_i.data[8*i +: 8];
                    end
                end
                w_idx_q <= next_idx(w_idx_q);
                if (w_i.last) begin
                    w_data_q  <= 1'b0;
                    b_valid_q <= 1'b1;
                end
            end
            if (b_valid_q && b_ready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////

    assign ar_ready_o = !r_active_q;
    assign r_valid_o  = r_active_q;
    assign r_o        = '{id: r_id_q, data: mem_q[r_idx_q], resp: AXI_RESP_OKAY,
                          last: (r_left_q == '0)};

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            r_active_q <= 1'b0;
            r_idx_q    <= '0;
            r_id_q     <= '0;
            r_left_q   <= '0;
        end else if (ar_valid_i && ar_ready_o) begin
            r_active_q <= 1'b1;
            r_idx_q    <= start_idx(ar_i.addr);
            r_id_q     <= ar_i.id;
            r_left_q   <= ar_i.len;
        end else if (r_valid_o && r_ready_i) begin
            if (r_o.last) begin
                r_active_q <= 1'b0;
            end else begin
                r_left_q <= r_left_q - 1'b1;
                r_idx_q  <= next_idx(r_idx_q);
            end
        end
    end

endmodule

// ==== rtl/loader_top.sv ====
`timescale 1ns/100ps

module loader_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int LOADER_ID  = 3,
    parameter int MEM_WORDS  = 16
) (
    input  logic                    clk_i,
    input  logic                    arstn_i,

    input  loader_pkg::loader_cmd_t cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,

    input  logic                    start_i,
    input  logic [7:0]              req_depth_i,
    output logic                    idle_o,

    output loader_pkg::loader_cpl_t cpl_o,
    output logic                    cpl_valid_o
);

    import axi_pkg::*;
    import loader_pkg::*;

    loader_cmd_t q_cmd;
    logic        q_valid, q_ready;

    axi_aw_t aw;
    axi_w_t  w;
    axi_ar_t ar;
    axi_b_t  b;
    axi_r_t  r;
    logic    aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic    b_valid, b_ready, r_valid, r_ready;

    loader_cpl_t wr_cpl, rd_cpl, held_q;
    logic        held_valid_q;
    logic        b_hs, r_last_hs;

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .data_i  (cmd_i),
        .valid_i (cmd_valid_i),
        .ready_o (cmd_ready_o),
        .data_o  (q_cmd),
        .valid_o (q_valid),
        .ready_i (q_ready)
    );

    axi_burst_loader #(
        .LOADER_ID (LOADER_ID)
    ) u_loader (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .start_i     (start_i),
        .req_depth_i (req_depth_i),
        .idle_o      (idle_o),
        .cmd_i       (q_cmd),
        .cmd_valid_i (q_valid),
        .cmd_ready_o (q_ready),
        .aw_o        (aw),
        .aw_valid_o  (aw_valid),
        .aw_ready_i  (aw_ready),
        .w_o         (w),
        .w_valid_o   (w_valid),
        .w_ready_i   (w_ready),
        .ar_o        (ar),
        .ar_valid_o  (ar_valid),
        .ar_ready_i  (ar_ready),
        .b_i         (b),
        .b_valid_i   (b_valid),
        .b_ready_o   (b_ready),
        .r_i         (r),
        .r_valid_i   (r_valid),
        .r_ready_o   (r_ready)
    );

    axi_mem_target #(
        .MEM_WORDS (MEM_WORDS)
    ) u_target (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .b_o        (b),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready)
    );

    ////////////////////////////////////////
    // Completion records
    ////////////////////////////////////////

    assign b_hs      = b_valid & b_ready;
    assign r_last_hs = r_valid & r_ready & r.last;

    assign wr_cpl = '{write: 1'b1, id: b.id, data: '0};
    assign rd_cpl = '{write: 1'b0, id: r.id, data: r.data};

    // Writes win a collision and the read goes out from the hold register
    assign cpl_valid_o = b_hs | held_valid_q | r_last_hs;
    assign cpl_o       = b_hs ? wr_cpl : (held_valid_q ? held_q : rd_cpl);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            held_valid_q <= 1'b0;
        end else if (b_hs && held_valid_q) begin
            held_valid_q <= 1'b1;
        end else begin
            held_valid_q <= r_last_hs && (b_hs || held_valid_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_last_hs && (b_hs || held_valid_q)) begin
            held_q <= rd_cpl;
        end
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic arstn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

    // Reset lets go on a falling edge, away from the DUT's active edge
    initial begin
        arstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arstn_o = 1'b1;
    end

endmodule

// ==== tb/loader_tb.sv ====
`timescale 1ns/100ps

module loader_tb;

    import axi_pkg::*;
    import loader_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int LOADER_ID  = 3;
    localparam int MEM_WORDS  = 16;
    localparam int IDX_W      = $clog2(MEM_WORDS);
    localparam int BASE_IDX   = (LOADER_ID * 4 / 4) % MEM_WORDS;
    localparam int TIMEOUT    = 1000;

    localparam logic [31:0]           SEED    = 32'h173d_ece7;
    localparam logic [AXI_DATA_W-1:0] WR_WORD = AXI_DATA_W'(32'h30 + LOADER_ID);

    logic        clk, arstn;
    loader_cmd_t cmd;
    logic        cmd_valid, cmd_ready;
    logic        start;
    logic [7:0]  req_depth;
    logic        idle;
    loader_cpl_t cpl;
    logic        cpl_valid;

    // Expected completions per direction, in issue order
    loader_cpl_t           wr_exp_q[$];
    loader_cpl_t           rd_exp_q[$];
    logic [AXI_DATA_W-1:0] model_mem [MEM_WORDS];
    int                    pending;

    logic check_reset, expect_full, quiet_check;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (2)
    ) u_clk_gen (
        .clk_o   (clk),
        .arstn_o (arstn)
    );

    loader_top dut (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .start_i     (start),
        .req_depth_i (req_depth),
        .idle_o      (idle),
        .cpl_o       (cpl),
        .cpl_valid_o (cpl_valid)
    );

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic loader_cmd_t make_cmd(input logic write, input logic [7:0] len);
        loader_cmd_t c;
        c.write = write;
        c.len   = len;
        c.id    = AXI_ID_W'($urandom);
        return c;
    endfunction

    // The model memory is updated at push time, so a read only sees
    // words that no write still in flight could change
    task automatic push_cmd(input loader_cmd_t c);
        int               waited;
        loader_cpl_t      exp_cpl;
        logic [IDX_W-1:0] widx;
        cmd       = c;
        cmd_valid = 1'b1;
        waited    = 0;
        while (!cmd_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmd_ready) begin
            report_fail("Timed out waiting for the command queue to accept a command");
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        if (c.write) begin
            for (int b = 0; b <= int'(c.len); b++) begin
                widx            = IDX_W'((BASE_IDX + b) % MEM_WORDS);
                model_mem[widx] = WR_WORD;
            end
            exp_cpl = '{write: 1'b1, id: c.id, data: '0};
            wr_exp_q.push_back(exp_cpl);
        end else begin
            widx    = IDX_W'((BASE_IDX + int'(c.len)) % MEM_WORDS);
            exp_cpl = '{write: 1'b0, id: c.id, data: model_mem[widx]};
            rd_exp_q.push_back(exp_cpl);
        end
        pending++;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!(idle && pending == 0) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!(idle && pending == 0)) begin
            report_fail("Timed out waiting for the loader to finish its completions");
        end
    endtask

    task automatic run_batch(input logic [7:0] depth);
        int waited;
        req_depth = depth;
        start     = 1'b1;
        waited    = 0;
        while (idle && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (idle) begin
            report_fail("Loader never left idle after start was raised");
        end
        wait_drained();
        start = 1'b0;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Completions are held for a whole cycle, so the middle of it is stable
    always @(negedge clk) begin : cpl_monitor
        loader_cpl_t exp_cpl;
        if (arstn && cpl_valid) begin
            if (cpl.write && wr_exp_q.size() == 0) begin
                report_fail("A write completion arrived with no write outstanding");
            end else if (!cpl.write && rd_exp_q.size() == 0) begin
                report_fail("A read completion arrived with no read outstanding");
            end else begin
                if (cpl.write) begin
                    exp_cpl = wr_exp_q.pop_front();
                end else begin
                    exp_cpl = rd_exp_q.pop_front();
                end
                pending--;
                assert (cpl.id == exp_cpl.id)
                    else report_fail($sformatf("[ERROR] cpl_o.id: got 0x%h, expected 0x%h",
                                               cpl.id, exp_cpl.id));
                assert (cpl.data == exp_cpl.data)
                    else report_fail($sformatf("[ERROR] cpl_o.data: got 0x%h, expected 0x%h",
                                               cpl.data, exp_cpl.data));
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        check_reset |-> (idle && cmd_ready && !cpl_valid))
        else report_fail($sformatf(
            "[ERROR] after reset idle_o=0x%h cmd_ready_o=0x%h cpl_valid_o=0x%h",
            $sampled(idle), $sampled(cmd_ready), $sampled(cpl_valid)));

    a_known: assert property (@(posedge clk) disable iff (!arstn)
        !$isunknown({idle, cmd_ready, cpl_valid}))
        else report_fail("An output among idle_o, cmd_ready_o and cpl_valid_o is unknown");

    a_full: assert property (@(posedge clk) disable iff (!arstn)
        expect_full |-> !cmd_ready)
        else report_fail($sformatf("[ERROR] cmd_ready_o: got 0x%h, expected 0x0",
                                   $sampled(cmd_ready)));

    a_idle_quiet: assert property (@(posedge clk) disable iff (!arstn)
        (quiet_check && idle) |-> !cpl_valid)
        else report_fail($sformatf("[ERROR] cpl_valid_o: got 0x%h while idle_o is high",
                                   $sampled(cpl_valid)));

    a_idle_drained: assert property (@(posedge clk) disable iff (!arstn)
        (quiet_check && $rose(idle)) |-> (pending == 0))
        else report_fail($sformatf("[ERROR] idle_o rose with 0x%h completions outstanding",
                                   $sampled(pending)));

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        loader_cmd_t c;
        int          waited;
        void'($urandom(SEED));
        cmd         = '0;
        cmd_valid   = 1'b0;
        start       = 1'b0;
        req_depth   = 8'd1;
        check_reset = 1'b0;
        expect_full = 1'b0;
        quiet_check = 1'b0;
        pending     = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end

        waited = 0;
        while (arstn !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (arstn !== 1'b1) begin
            report_fail("Reset was never released");
        end
        @(negedge clk);
        check_reset = 1'b1;
        @(negedge clk);
        check_reset = 1'b0;

        // A read ahead of any write sees the reset contents
        push_cmd(make_cmd(1'b0, 8'($urandom_range(7, 0))));
        run_batch(8'd4);

        // The last write covers every word of the memory
        for (int i = 0; i < 4; i++) begin
            push_cmd(make_cmd(1'b1, 8'($urandom_range(15, 0))));
        end
        push_cmd(make_cmd(1'b1, 8'd15));
        run_batch(8'd5);

        for (int i = 0; i < 4; i++) begin
            push_cmd(make_cmd(1'b0, 8'($urandom_range(15, 0))));
        end
        run_batch(8'd4);

        // Five writes spread over batches of two
        for (int i = 0; i < 5; i++) begin
            push_cmd(make_cmd(1'b1, 8'($urandom_range(7, 0))));
        end
        quiet_check = 1'b1;
        run_batch(8'd2);
        repeat (3) @(negedge clk);
        quiet_check = 1'b0;

        // Overfill the queue while the loader sits idle
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            push_cmd(make_cmd(1'($urandom_range(1, 0)), 8'($urandom_range(7, 0))));
        end
        c         = make_cmd(1'b1, 8'($urandom_range(7, 0)));
        cmd       = c;
        cmd_valid = 1'b1;
        expect_full = 1'b1;
        repeat (4) @(negedge clk);
        expect_full = 1'b0;
        req_depth   = 8'd3;
        start       = 1'b1;
        push_cmd(c);
        push_cmd(make_cmd(1'b0, 8'($urandom_range(7, 0))));
        wait_drained();
        start = 1'b0;

        // Read len L+2 ahead of write len L ends both bursts on one cycle
        quiet_check = 1'b1;
        for (int i = 0; i < 4; i++) begin
            push_cmd(make_cmd(1'b0, 8'(i + 2)));
            push_cmd(make_cmd(1'b1, 8'(i)));
            run_batch(8'd2);
        end

        repeat (5) @(negedge clk);
        if (wr_exp_q.size() != 0 || rd_exp_q.size() != 0) begin
            report_fail("Expected completions are still outstanding at the end of the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
rtl/axi_pkg.sv
rtl/loader_pkg.sv
rtl/cmd_fifo.sv
rtl/axi_burst_loader.sv
rtl/axi_mem_target.sv
rtl/loader_top.sv
tb/tb_clock_gen.sv
tb/loader_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= loader_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Simulation completed successfully
FAIL_MSG  ?= Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
